// ==== design/e0c_settings.svh ====
`ifndef E0C_SETTINGS_SVH
`define E0C_SETTINGS_SVH

// Every instruction of the group takes this many clocks
`define E0C_INSTR_CYCLES 7

// Data memory and index register width
`define E0C_ADDR_W 12

// Opcode width
`define E0C_OP_W 12

`endif

// ==== design/e0c_isa_pkg.sv ====
`default_nettype none

`include "e0c_settings.svh"

package e0c_isa_pkg;

    typedef logic [3:0] nibble_t;
    typedef logic [`E0C_ADDR_W-1:0] addr_t;

    // Decoded instruction group
    typedef enum logic [2:0] {
        op_none    = 3'd0,
        adc_xy_imm = 3'd1, // ADC XH/XL/YH/YL,i
        adc_rq     = 3'd2, // ADC r,q
        adc_r_imm  = 3'd3, // ADC r,i
        acpx       = 3'd4, // ACPX MX,r
        acpy       = 3'd5  // ACPY MY,r
    } opgrp_e;

    // r and q operand field encoding
    typedef enum logic [1:0] {
        sel_a  = 2'd0,
        sel_b  = 2'd1,
        sel_mx = 2'd2,
        sel_my = 2'd3
    } rsel_e;

endpackage

`default_nettype wire

// ==== design/e0c_core_pkg.sv ====
`default_nettype none

package e0c_core_pkg;

    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_decode = 3'd1,
        st_read   = 3'd2,
        st_exec   = 3'd3,
        st_write  = 3'd4,
        st_wait   = 3'd5,
        st_done   = 3'd6
    } seq_state_e;

    // Host port access target
    typedef enum logic [2:0] {
        tgt_a     = 3'd0,
        tgt_b     = 3'd1,
        tgt_x     = 3'd2,
        tgt_y     = 3'd3,
        tgt_pc    = 3'd4,
        tgt_flags = 3'd5,
        tgt_mem   = 3'd6
    } host_tgt_e;

endpackage

`default_nettype wire

// ==== design/e0c_reg_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface e0c_reg_if;

    // Architectural state, driven by the register file
    e0c_isa_pkg::nibble_t a;
    e0c_isa_pkg::nibble_t b;
    e0c_isa_pkg::addr_t   x;
    e0c_isa_pkg::addr_t   y;
    e0c_isa_pkg::addr_t   pc;
    logic                 carry;
    logic                 decimal;

    // Single-cycle write strobes from the sequencer
    logic                 wr_a;
    e0c_isa_pkg::nibble_t a_wdata;
    logic                 wr_b;
    e0c_isa_pkg::nibble_t b_wdata;
    logic                 wr_x;
    e0c_isa_pkg::addr_t   x_wdata;
    logic                 wr_y;
    e0c_isa_pkg::addr_t   y_wdata;
    logic                 pc_inc;
    logic                 flag_we;
    logic                 new_carry;
    logic                 new_zero;

    modport seq (
        input  a, b, x, y, pc, carry, decimal,
        output wr_a, a_wdata, wr_b, b_wdata, wr_x, x_wdata, wr_y, y_wdata,
        output pc_inc, flag_we, new_carry, new_zero
    );

    modport rf (
        output a, b, x, y, pc, carry, decimal,
        input  wr_a, a_wdata, wr_b, b_wdata, wr_x, x_wdata, wr_y, y_wdata,
        input  pc_inc, flag_we, new_carry, new_zero
    );

endinterface

`default_nettype wire

// ==== design/e0c_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module e0c_alu (
    input  wire e0c_isa_pkg::nibble_t op_a,
    input  wire e0c_isa_pkg::nibble_t op_b,
    input  wire logic                 carry_in,
    input  wire logic                 decimal,
    output e0c_isa_pkg::nibble_t      sum,
    output logic                      carry_out
);

    logic [4:0] raw;
    logic [4:0] adjusted;

    assign raw      = {1'b0, op_a} + {1'b0, op_b} + {4'b0, carry_in};
    assign adjusted = raw - 5'd10;

    always_comb begin
        if (decimal && raw >= 5'd10) begin
            // BCD adjust
            sum       = adjusted[3:0];
            carry_out = 1'b1;
        end else begin
            sum       = raw[3:0];
            carry_out = raw[4];
        end
    end

endmodule

`default_nettype wire

// ==== design/e0c_data_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "e0c_settings.svh"

module e0c_data_ram (
    input  wire logic                 clk,
    input  wire e0c_isa_pkg::addr_t   mem_addr,
    input  wire logic                 mem_we,
    input  wire e0c_isa_pkg::nibble_t mem_wdata,
    output e0c_isa_pkg::nibble_t      mem_rdata,
    input  wire e0c_isa_pkg::addr_t   host_addr,
    input  wire logic                 host_we_mem,
    input  wire e0c_isa_pkg::nibble_t host_wdata,
    output e0c_isa_pkg::nibble_t      host_rdata_mem
);

    e0c_isa_pkg::nibble_t mem [0:(1 << `E0C_ADDR_W) - 1];

    always_ff @(posedge clk) begin
        if (host_we_mem)
            mem[host_addr] <= host_wdata;
        if (mem_we)
            mem[mem_addr] <= mem_wdata; // Later assignment, sequencer wins
    end

    assign mem_rdata      = mem[mem_addr];
    assign host_rdata_mem = mem[host_addr];

endmodule

`default_nettype wire

// ==== design/e0c_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module e0c_regfile (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    e0c_reg_if.rf                         regs,
    input  wire logic                     host_we,
    input  wire e0c_core_pkg::host_tgt_e  host_tgt,
    input  wire e0c_isa_pkg::addr_t       host_wdata,
    input  wire logic                     busy,
    output e0c_isa_pkg::nibble_t          a_o,
    output e0c_isa_pkg::nibble_t          b_o,
    output e0c_isa_pkg::addr_t            x_o,
    output e0c_isa_pkg::addr_t            y_o,
    output e0c_isa_pkg::addr_t            pc_o,
    output logic [2:0]                    flags_o
);

    e0c_isa_pkg::nibble_t a;
    e0c_isa_pkg::nibble_t b;
    e0c_isa_pkg::addr_t   x;
    e0c_isa_pkg::addr_t   y;
    e0c_isa_pkg::addr_t   pc;
    logic                 carry;
    logic                 zero;
    logic                 decimal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a       <= '0;
            b       <= '0;
            x       <= '0;
            y       <= '0;
            pc      <= '0;
            carry   <= 1'b0;
            zero    <= 1'b0;
            decimal <= 1'b0;
        end else begin
            if (regs.wr_a) a <= regs.a_wdata;
            if (regs.wr_b) b <= regs.b_wdata;
            if (regs.wr_x) x <= regs.x_wdata;
            if (regs.wr_y) y <= regs.y_wdata;
            if (regs.pc_inc)
                pc <= pc + e0c_isa_pkg::addr_t'(1);
            if (regs.flag_we) begin
                carry <= regs.new_carry;
                zero  <= regs.new_zero;
            end

            // Host preset, only between instructions
            if (host_we && !busy) begin
                case (host_tgt)
                    e0c_core_pkg::tgt_a:  a  <= host_wdata[3:0];
                    e0c_core_pkg::tgt_b:  b  <= host_wdata[3:0];
                    e0c_core_pkg::tgt_x:  x  <= host_wdata;
                    e0c_core_pkg::tgt_y:  y  <= host_wdata;
                    e0c_core_pkg::tgt_pc: pc <= host_wdata;
                    e0c_core_pkg::tgt_flags: begin
                        carry   <= host_wdata[0];
                        zero    <= host_wdata[1];
                        decimal <= host_wdata[2];
                    end
                    default: ; // Memory lives in the RAM
                endcase
            end
        end
    end

    assign regs.a       = a;
    assign regs.b       = b;
    assign regs.x       = x;
    assign regs.y       = y;
    assign regs.pc      = pc;
    assign regs.carry   = carry;
    assign regs.decimal = decimal;

    assign a_o     = a;
    assign b_o     = b;
    assign x_o     = x;
    assign y_o     = y;
    assign pc_o    = pc;
    assign flags_o = {decimal, zero, carry};

endmodule

`default_nettype wire

// ==== design/e0c_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "e0c_settings.svh"

module e0c_sequencer (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 instr_valid,
    input  wire logic [`E0C_OP_W-1:0] instr,
    e0c_reg_if.seq                    regs,
    output e0c_isa_pkg::addr_t        mem_addr,
    input  wire e0c_isa_pkg::nibble_t mem_rdata,
    output logic                      mem_we,
    output e0c_isa_pkg::nibble_t      mem_wdata,
    output logic                      busy,
    output logic                      done
);

    localparam int CNT_W = $clog2(`E0C_INSTR_CYCLES + 1);

    e0c_core_pkg::seq_state_e state;
    logic [CNT_W-1:0]         cnt;      // Cycle within the instruction
    logic [`E0C_OP_W-1:0]     instr_q;

    e0c_isa_pkg::opgrp_e      grp;
    e0c_isa_pkg::rsel_e       a_src;
    e0c_isa_pkg::rsel_e       b_src;
    e0c_isa_pkg::rsel_e       cur_src;
    logic                     use_imm;
    logic [1:0]               idx_sel;  // XH, XL, YH, YL
    e0c_isa_pkg::nibble_t     idx_nib;
    e0c_isa_pkg::nibble_t     fetch_val;

    e0c_isa_pkg::nibble_t     op_a_q;
    e0c_isa_pkg::nibble_t     op_b_q;
    e0c_isa_pkg::nibble_t     sum;
    e0c_isa_pkg::nibble_t     sum_q;
    logic                     carry_out;
    logic                     carry_q;
    logic                     commit;
    logic                     to_reg;

    // Opcode decode
    always_comb begin
        grp     = e0c_isa_pkg::op_none;
        a_src   = e0c_isa_pkg::sel_a;
        b_src   = e0c_isa_pkg::sel_a;
        use_imm = 1'b0;
        idx_sel = instr_q[5:4];
        if (instr_q[11:6] == 6'b1010_00) begin
            grp     = e0c_isa_pkg::adc_xy_imm;
            use_imm = 1'b1;
        end else if (instr_q[11:4] == 8'hA9) begin
            grp   = e0c_isa_pkg::adc_rq;
            a_src = e0c_isa_pkg::rsel_e'(instr_q[3:2]);
            b_src = e0c_isa_pkg::rsel_e'(instr_q[1:0]);
        end else if (instr_q[11:6] == 6'b1100_01) begin
            grp     = e0c_isa_pkg::adc_r_imm;
            a_src   = e0c_isa_pkg::rsel_e'(instr_q[5:4]);
            use_imm = 1'b1;
        end else if (instr_q[11:2] == 10'b1111_0010_10) begin
            grp   = e0c_isa_pkg::acpx;
            a_src = e0c_isa_pkg::sel_mx;
            b_src = e0c_isa_pkg::rsel_e'(instr_q[1:0]);
        end else if (instr_q[11:2] == 10'b1111_0010_11) begin
            grp   = e0c_isa_pkg::acpy;
            a_src = e0c_isa_pkg::sel_my;
            b_src = e0c_isa_pkg::rsel_e'(instr_q[1:0]);
        end
    end

    // r is fetched in decode, q in read, r is written back in write
    assign cur_src  = (state == e0c_core_pkg::st_read) ? b_src : a_src;
    assign mem_addr = (cur_src == e0c_isa_pkg::sel_my) ? regs.y : regs.x;

    always_comb begin
        case (cur_src)
            e0c_isa_pkg::sel_a: fetch_val = regs.a;
            e0c_isa_pkg::sel_b: fetch_val = regs.b;
            default:            fetch_val = mem_rdata;
        endcase
    end

    always_comb begin
        case (idx_sel)
            2'd0:    idx_nib = regs.x[7:4];
            2'd1:    idx_nib = regs.x[3:0];
            2'd2:    idx_nib = regs.y[7:4];
            default: idx_nib = regs.y[3:0];
        endcase
    end

    e0c_alu i_alu (
        .op_a      (op_a_q),
        .op_b      (op_b_q),
        .carry_in  (regs.carry),
        .decimal   (regs.decimal && grp != e0c_isa_pkg::adc_xy_imm), // Index adds are binary
        .sum       (sum),
        .carry_out (carry_out)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= e0c_core_pkg::st_idle;
            cnt   <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                e0c_core_pkg::st_idle: begin
                    cnt <= '0;
                    if (instr_valid) begin
                        state <= e0c_core_pkg::st_decode;
                        cnt   <= CNT_W'(1);
                    end
                end
                e0c_core_pkg::st_decode: state <= e0c_core_pkg::st_read;
                e0c_core_pkg::st_read:   state <= e0c_core_pkg::st_exec;
                e0c_core_pkg::st_exec:   state <= e0c_core_pkg::st_write;
                e0c_core_pkg::st_write:  state <= e0c_core_pkg::st_wait;
                e0c_core_pkg::st_wait: begin
                    if (cnt == CNT_W'(`E0C_INSTR_CYCLES - 1))
                        state <= e0c_core_pkg::st_done;
                end
                default: state <= e0c_core_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == e0c_core_pkg::st_idle && instr_valid)
            instr_q <= instr;
        if (state == e0c_core_pkg::st_decode)
            op_a_q <= (grp == e0c_isa_pkg::adc_xy_imm) ? idx_nib : fetch_val;
        if (state == e0c_core_pkg::st_read)
            op_b_q <= use_imm ? instr_q[3:0] : fetch_val;
        if (state == e0c_core_pkg::st_exec) begin
            sum_q   <= sum;
            carry_q <= carry_out;
        end
    end

    // Write-back
    assign commit = (state == e0c_core_pkg::st_write) && (grp != e0c_isa_pkg::op_none);
    assign to_reg = (grp == e0c_isa_pkg::adc_rq) || (grp == e0c_isa_pkg::adc_r_imm);

    assign regs.wr_a    = commit && to_reg && (a_src == e0c_isa_pkg::sel_a);
    assign regs.wr_b    = commit && to_reg && (a_src == e0c_isa_pkg::sel_b);
    assign regs.a_wdata = sum_q;
    assign regs.b_wdata = sum_q;

    assign mem_we    = commit && (a_src == e0c_isa_pkg::sel_mx || a_src == e0c_isa_pkg::sel_my);
    assign mem_wdata = sum_q;

    assign regs.wr_x = commit && ((grp == e0c_isa_pkg::adc_xy_imm && !idx_sel[1])
                                  || grp == e0c_isa_pkg::acpx);
    assign regs.wr_y = commit && ((grp == e0c_isa_pkg::adc_xy_imm && idx_sel[1])
                                  || grp == e0c_isa_pkg::acpy);

    // ACP post-increments, the memory write still uses the old index
    assign regs.x_wdata = (grp == e0c_isa_pkg::acpx) ? regs.x + e0c_isa_pkg::addr_t'(1) :
                          idx_sel[0] ? {regs.x[11:4], sum_q} :
                                       {regs.x[11:8], sum_q, regs.x[3:0]};
    assign regs.y_wdata = (grp == e0c_isa_pkg::acpy) ? regs.y + e0c_isa_pkg::addr_t'(1) :
                          idx_sel[0] ? {regs.y[11:4], sum_q} :
                                       {regs.y[11:8], sum_q, regs.y[3:0]};

    assign regs.flag_we   = commit;
    assign regs.new_carry = carry_q;
    assign regs.new_zero  = (sum_q == 4'h0);
    assign regs.pc_inc    = (state == e0c_core_pkg::st_write);

    assign busy = (state != e0c_core_pkg::st_idle);
    assign done = (state == e0c_core_pkg::st_done);

endmodule

`default_nettype wire

// ==== design/e0c_adc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "e0c_settings.svh"

module e0c_adc_unit (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    instr_valid,
    input  wire logic [`E0C_OP_W-1:0]    instr,
    output logic                         busy,
    output logic                         done,
    input  wire logic                    host_we,
    input  wire e0c_core_pkg::host_tgt_e host_tgt,
    input  wire e0c_isa_pkg::addr_t      host_addr,
    input  wire e0c_isa_pkg::addr_t      host_wdata,
    output e0c_isa_pkg::addr_t           host_rdata
);

    e0c_isa_pkg::nibble_t a_o;
    e0c_isa_pkg::nibble_t b_o;
    e0c_isa_pkg::addr_t   x_o;
    e0c_isa_pkg::addr_t   y_o;
    e0c_isa_pkg::addr_t   pc_o;
    logic [2:0]           flags_o;

    e0c_isa_pkg::addr_t   mem_addr;
    e0c_isa_pkg::nibble_t mem_rdata;
    logic                 mem_we;
    e0c_isa_pkg::nibble_t mem_wdata;
    e0c_isa_pkg::nibble_t host_rdata_mem;
    logic                 host_we_mem;

    e0c_reg_if regs();

    e0c_regfile i_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .regs       (regs.rf),
        .host_we    (host_we),
        .host_tgt   (host_tgt),
        .host_wdata (host_wdata),
        .busy       (busy),
        .a_o        (a_o),
        .b_o        (b_o),
        .x_o        (x_o),
        .y_o        (y_o),
        .pc_o       (pc_o),
        .flags_o    (flags_o)
    );

    e0c_sequencer i_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .regs        (regs.seq),
        .mem_addr    (mem_addr),
        .mem_rdata   (mem_rdata),
        .mem_we      (mem_we),
        .mem_wdata   (mem_wdata),
        .busy        (busy),
        .done        (done)
    );

    assign host_we_mem = host_we && !busy && (host_tgt == e0c_core_pkg::tgt_mem);

    e0c_data_ram i_data_ram (
        .clk            (clk),
        .mem_addr       (mem_addr),
        .mem_we         (mem_we),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .host_addr      (host_addr),
        .host_we_mem    (host_we_mem),
        .host_wdata     (host_wdata[3:0]),
        .host_rdata_mem (host_rdata_mem)
    );

    // Host readback
    always_comb begin
        case (host_tgt)
            e0c_core_pkg::tgt_a:     host_rdata = {8'h00, a_o};
            e0c_core_pkg::tgt_b:     host_rdata = {8'h00, b_o};
            e0c_core_pkg::tgt_x:     host_rdata = x_o;
            e0c_core_pkg::tgt_y:     host_rdata = y_o;
            e0c_core_pkg::tgt_pc:    host_rdata = pc_o;
            e0c_core_pkg::tgt_flags: host_rdata = {9'h000, flags_o};
            e0c_core_pkg::tgt_mem:   host_rdata = {8'h00, host_rdata_mem};
            default:                 host_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== test/adc_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "e0c_settings.svh"

module adc_tb;

    localparam int RESET_CYCLES = 16;
    localparam int REC_W        = 18;  // Words per pattern record
    localparam int MAX_PAT      = 64;
    localparam int CYCLE_BUDGET = `E0C_INSTR_CYCLES + 40;

    // Record layout with the presets first
    localparam int F_OP = 0;
    localparam int F_A  = 1;
    localparam int F_B  = 2;
    localparam int F_X  = 3;
    localparam int F_Y  = 4;
    localparam int F_C  = 5;
    localparam int F_D  = 6;
    localparam int F_MX = 7;
    localparam int F_MY = 8;
    localparam int E_A  = 9;
    localparam int E_B  = 10;
    localparam int E_X  = 11;
    localparam int E_Y  = 12;
    localparam int E_PC = 13;
    localparam int E_C  = 14;
    localparam int E_Z  = 15;
    localparam int E_MX = 16;
    localparam int E_MY = 17;

    logic                    clk;
    logic                    rst_n;
    logic                    instr_valid;
    logic [`E0C_OP_W-1:0]    instr;
    logic                    busy;
    logic                    done;
    logic                    host_we;
    e0c_core_pkg::host_tgt_e host_tgt;
    e0c_isa_pkg::addr_t      host_addr;
    e0c_isa_pkg::addr_t      host_wdata;
    e0c_isa_pkg::addr_t      host_rdata;

    logic [11:0] pat_mem [0:MAX_PAT*REC_W];
    int          n_pat;

    tb_clock_gen i_clock_gen (
        .clk (clk)
    );

    e0c_adc_unit i_e0c_adc_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .busy        (busy),
        .done        (done),
        .host_we     (host_we),
        .host_tgt    (host_tgt),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata)
    );

    task automatic check_value(input string sig, input logic [11:0] actual,
                               input logic [11:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%03h, expected 0x%03h", sig, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic host_write(input e0c_core_pkg::host_tgt_e tgt, input logic [11:0] addr,
                              input logic [11:0] data);
        @(posedge clk);
        host_we    <= 1'b1;
        host_tgt   <= tgt;
        host_addr  <= addr;
        host_wdata <= data;
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    task automatic host_read(input e0c_core_pkg::host_tgt_e tgt, input logic [11:0] addr,
                             output logic [11:0] value);
        @(posedge clk);
        host_tgt  <= tgt;
        host_addr <= addr;
        @(negedge clk);
        value = host_rdata;
    endtask

    // Returns at the accepting edge
    task automatic start_instr(input logic [11:0] op);
        @(posedge clk);
        instr       <= op;
        instr_valid <= 1'b1;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic wait_done(output logic [11:0] cycles);
        cycles = '0;
        do begin
            @(negedge clk);
            cycles = cycles + 12'd1;
            check_value("busy while running", {11'b0, busy}, 12'h001);
        end while (!done && cycles < 12'(4 * `E0C_INSTR_CYCLES));
        if (!done)
            abort_run($sformatf("done did not arrive within %0d cycles", cycles));
        @(negedge clk);
        check_value("done width", {11'b0, done}, 12'h000); // One-cycle pulse
        check_value("busy after done", {11'b0, busy}, 12'h000);
    endtask

    task automatic run_record(input int idx);
        logic [11:0] r [0:REC_W-1];
        logic [11:0] rd;
        logic [11:0] lat;
        string       tag;
        tag = $sformatf("record %0d ", idx);
        for (int k = 0; k < REC_W; k++)
            r[k] = pat_mem[idx*REC_W + k];

        host_write(e0c_core_pkg::tgt_a, 12'h000, r[F_A]);
        host_write(e0c_core_pkg::tgt_b, 12'h000, r[F_B]);
        host_write(e0c_core_pkg::tgt_x, 12'h000, r[F_X]);
        host_write(e0c_core_pkg::tgt_y, 12'h000, r[F_Y]);
        host_write(e0c_core_pkg::tgt_flags, 12'h000, {9'b0, r[F_D][0], 1'b0, r[F_C][0]});
        host_write(e0c_core_pkg::tgt_mem, r[F_X], r[F_MX]);
        host_write(e0c_core_pkg::tgt_mem, r[F_Y], r[F_MY]);

        start_instr(r[F_OP]);
        wait_done(lat);
        check_value({tag, "done latency"}, lat, 12'(`E0C_INSTR_CYCLES));

        host_read(e0c_core_pkg::tgt_a, 12'h000, rd);
        check_value({tag, "a"}, rd, r[E_A]);
        host_read(e0c_core_pkg::tgt_b, 12'h000, rd);
        check_value({tag, "b"}, rd, r[E_B]);
        host_read(e0c_core_pkg::tgt_x, 12'h000, rd);
        check_value({tag, "x"}, rd, r[E_X]);
        host_read(e0c_core_pkg::tgt_y, 12'h000, rd);
        check_value({tag, "y"}, rd, r[E_Y]);
        host_read(e0c_core_pkg::tgt_pc, 12'h000, rd);
        check_value({tag, "pc"}, rd, r[E_PC]);
        host_read(e0c_core_pkg::tgt_flags, 12'h000, rd);
        check_value({tag, "carry"}, {11'b0, rd[0]}, r[E_C]);
        check_value({tag, "zero"}, {11'b0, rd[1]}, r[E_Z]);
        check_value({tag, "decimal"}, {11'b0, rd[2]}, r[F_D]); // Never written by ADC
        host_read(e0c_core_pkg::tgt_mem, r[F_X], rd);
        check_value({tag, "mem[old x]"}, rd, r[E_MX]);
        host_read(e0c_core_pkg::tgt_mem, r[F_Y], rd);
        check_value({tag, "mem[old y]"}, rd, r[E_MY]);
    endtask

    // Opcode and host write sent mid-instruction must both be dropped
    task automatic check_busy_strobe();
        logic [11:0] pc0;
        logic [11:0] rd;
        logic [11:0] lat;
        host_write(e0c_core_pkg::tgt_a, 12'h000, 12'h001);
        host_write(e0c_core_pkg::tgt_b, 12'h000, 12'h002);
        host_write(e0c_core_pkg::tgt_flags, 12'h000, 12'h000);
        host_read(e0c_core_pkg::tgt_pc, 12'h000, pc0);

        start_instr(12'hA91); // ADC A,B
        repeat (2) @(posedge clk);
        instr       <= 12'hC4F;
        instr_valid <= 1'b1;
        host_we     <= 1'b1;
        host_tgt    <= e0c_core_pkg::tgt_b;
        host_wdata  <= 12'h009;
        @(posedge clk);
        instr_valid <= 1'b0;
        host_we     <= 1'b0;
        wait_done(lat);
        // Three cycles already spent before the second strobe
        check_value("busy test done latency", lat, 12'(`E0C_INSTR_CYCLES - 3));

        host_read(e0c_core_pkg::tgt_pc, 12'h000, rd);
        check_value("busy test pc", rd, pc0 + 12'd1);
        host_read(e0c_core_pkg::tgt_a, 12'h000, rd);
        check_value("busy test a", rd, 12'h003);
        host_read(e0c_core_pkg::tgt_b, 12'h000, rd);
        check_value("busy test b", rd, 12'h002);
        repeat (3 * `E0C_INSTR_CYCLES) begin
            @(negedge clk);
            check_value("busy test busy", {11'b0, busy}, 12'h000);
            check_value("busy test done", {11'b0, done}, 12'h000);
        end
    endtask

    initial begin
        logic                    found;
        logic [11:0]             rd;
        e0c_core_pkg::host_tgt_e tgt;
        instr_valid = 1'b0;
        instr       = '0;
        host_we     = 1'b0;
        host_tgt    = e0c_core_pkg::tgt_a;
        host_addr   = '0;
        host_wdata  = '0;
        rst_n       = 1'b0;

        $readmemh("test/adc_patterns.hex", pat_mem);
        found = 1'b0;
        n_pat = 0;
        for (int i = 0; i < MAX_PAT && !found; i++) begin
            if (pat_mem[i*REC_W] === 12'hFFF) begin // End marker
                found = 1'b1;
                n_pat = i;
            end
        end
        if (!found || n_pat == 0)
            abort_run("Pattern file has no records or lacks the FFF end marker");

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Registers, PC and flags all clear
        for (int t = 0; t <= 5; t++) begin
            tgt = e0c_core_pkg::host_tgt_e'(t);
            host_read(tgt, 12'h000, rd);
            check_value({tgt.name(), " after reset"}, rd, 12'h000);
        end
        check_value("busy after reset", {11'b0, busy}, 12'h000);
        check_value("done after reset", {11'b0, done}, 12'h000);

        for (int i = 0; i < n_pat; i++)
            run_record(i);
        check_busy_strobe();

        $display("Simulation completed successfully");
        $finish;
    end

    // Budget covers reset, every record and the busy test
    initial begin
        #1;
        repeat (RESET_CYCLES + (n_pat + 2) * CYCLE_BUDGET) @(posedge clk);
        $display("Watchdog timeout, the tests did not finish in the allowed cycles");
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== test/adc_patterns.hex ====
// op a b x y c d m(x) m(y)  then expected  a b x y pc c z m(old x) m(old y)
// A record with only FFF ends the list
// ADC XH/XL/YH/YL,i, always binary
A05 3 7 123 456 0 0 1 2  3 7 173 456 001 0 0 1 2
A19 0 F 2A7 300 1 1 4 5  0 F 2A1 300 002 1 0 4 5
A2F 5 6 040 810 0 0 9 A  5 6 040 800 003 1 1 9 A
A33 1 2 555 FFC 1 0 3 4  1 2 555 FF0 004 1 1 3 4
// ADC r,q binary
A91 3 4 010 020 0 0 0 0  7 4 010 020 005 0 0 0 0
A94 9 8 011 021 1 0 6 7  9 2 011 021 006 1 0 6 7
A90 8 1 012 022 0 0 2 3  0 1 012 022 007 1 1 2 3
A95 2 5 013 023 1 0 1 1  2 B 013 023 008 0 0 1 1
A92 6 0 100 200 0 0 9 4  F 0 100 200 009 0 0 9 4
A97 1 E 101 201 1 0 5 3  1 2 101 201 00A 1 0 5 3
A98 4 0 102 202 0 0 7 8  4 0 102 202 00B 0 0 B 8
A9D 0 1 103 203 0 0 2 F  0 1 103 203 00C 1 1 2 0
A9B 0 0 104 204 1 0 2 3  0 0 104 204 00D 0 0 6 3
A9E 0 0 105 205 0 0 A A  0 0 105 205 00E 1 0 A 4
// ADC r,i decimal
C47 5 3 110 210 0 1 0 0  2 3 110 210 00F 1 0 0 0
C59 0 9 111 211 1 1 0 0  0 9 111 211 010 1 0 0 0
C64 0 0 112 212 0 1 3 8  0 0 112 212 011 0 0 7 8
C71 0 0 113 213 1 1 6 8  0 0 113 213 012 1 1 6 0
// ACPX and ACPY
F28 6 0 1FF 300 0 0 5 2  6 0 200 300 013 0 0 B 2
F2B 0 0 FFF 010 1 1 8 5  0 0 000 010 014 1 0 4 5
F2D 0 C 0A0 0AF 0 0 1 3  0 C 0A0 0B0 015 0 0 1 F
F2E 0 0 123 7FF 0 0 1 F  0 0 123 800 016 1 1 1 0
FFF

// ==== src.f ====
+incdir+design
design/e0c_isa_pkg.sv
design/e0c_core_pkg.sv
design/e0c_reg_if.sv
design/e0c_alu.sv
design/e0c_data_ram.sv
design/e0c_regfile.sv
design/e0c_sequencer.sv
design/e0c_adc_unit.sv
test/tb_clock_gen.sv
test/adc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ADC unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module adc_tb -o adc_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/adc_tb_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
